// File: files.f
hw/soc_io_pkg.sv
hw/io_bus_decode.sv
hw/io_out_regs.sv
hw/kbd_fifo.sv
hw/soc_io.sv
verification/soc_io_checker.sv
verification/soc_io_assert.sv
verification/tb_soc_io.sv

// File: hw/io_bus_decode.sv
//**************************************************************************
// Combinational decoder for the peripheral region. Raises one strobe per
// matching access and muxes the read data back in the same cycle.
//**************************************************************************

`timescale 1ns/100ps

module io_bus_decode (
    input  soc_io_pkg::cpu_bus_t    bus_i,
    input  soc_io_pkg::uart_in_t    uart_i,
    input  soc_io_pkg::usb_report_t usb_report_i,
    input  logic                    usb_valid_i,
    input  logic                    kbd_not_empty_i,
    input  soc_io_pkg::byte_t       kbd_code_i,
    output soc_io_pkg::io_strobe_t  strobe_o,
    output soc_io_pkg::word_t       rdata_o
);
    import soc_io_pkg::*;

    logic        periph;
    logic [3:0]  dev;
    logic [11:0] ofs;

    assign periph = (bus_i.addr[31:28] == REGION_PERIPH);
    assign dev    = bus_i.addr[15:12];
    assign ofs    = bus_i.addr[11:0];

    // Strobes
    always_comb begin
        strobe_o = '0;
        if (periph) begin
            if (bus_i.we) begin
                case (dev)
                    DEV_DISPLAY: begin
                        // Any offset inside the display page
                        strobe_o.display_wr = 1'b1;
                    end
                    DEV_UART: begin
                        strobe_o.uart_tx = (ofs == OFS_DATA);
                    end
                    DEV_KBD: begin
                        // Emptiness is checked inside the queue
                        strobe_o.kbd_pop = (ofs == OFS_DATA);
                    end
                    default: begin
                        strobe_o = '0;
                    end
                endcase
            end else if ((dev == DEV_UART) && (ofs == OFS_DATA)) begin
                // Reading the rx byte acknowledges it to the UART core
                strobe_o.uart_rx = 1'b1;
            end
        end
    end

    // Read data mux, zero for anything unmapped
    always_comb begin
        rdata_o = '0;
        if (periph && !bus_i.we) begin
            case (dev)
                DEV_UART: begin
                    if (ofs == OFS_DATA) begin
                        rdata_o = {24'd0, uart_i.rx_data};
                    end else if (ofs == OFS_STATUS) begin
                        rdata_o = {30'd0, uart_i.valid, uart_i.busy};
                    end
                end
                DEV_USB: begin
                    if (ofs == OFS_DATA) begin
                        rdata_o = {31'd0, usb_valid_i};
                    end else if (ofs == OFS_STATUS) begin
                        // High word sits at offset 4
                        rdata_o = usb_report_i[63:32];
                    end else if (ofs == OFS_LSW) begin
                        rdata_o = usb_report_i[31:0];
                    end
                end
                DEV_KBD: begin
                    if (ofs == OFS_DATA) begin
                        rdata_o = {31'd0, kbd_not_empty_i};
                    end else if (ofs == OFS_STATUS) begin
                        rdata_o = {24'd0, kbd_code_i};
                    end
                end
                default: begin
                    rdata_o = '0;
                end
            endcase
        end
    end

endmodule

// File: hw/io_out_regs.sv
//**************************************************************************
// Display register and the registered UART write/read pulses. Strobes
// from the decoder take effect on the next clock edge.
//**************************************************************************

`timescale 1ns/100ps

module io_out_regs (
    input  logic                   clk,
    input  logic                   reset_i,
    input  soc_io_pkg::io_strobe_t strobe_i,
    input  soc_io_pkg::word_t      wdata_i,
    output soc_io_pkg::byte_t      display_o,
    output logic                   uart_wr_o,
    output logic                   uart_rd_o,
    output soc_io_pkg::byte_t      uart_tx_data_o
);

    // Display and UART pulse control
    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o <= '0;
            uart_wr_o <= 1'b0;
            uart_rd_o <= 1'b0;
        end else begin
            if (strobe_i.display_wr) begin
                display_o <= wdata_i[7:0];
            end
            // Strobes last a single bus cycle, so the pulses do too
            uart_wr_o <= strobe_i.uart_tx;
            uart_rd_o <= strobe_i.uart_rx;
        end
    end

    // Transmit byte, valid alongside uart_wr_o
    always_ff @(posedge clk) begin
        if (strobe_i.uart_tx) begin
            uart_tx_data_o <= wdata_i[7:0];
        end
    end

endmodule

// File: hw/kbd_fifo.sv
//**************************************************************************
// PS/2 keyboard code queue. Strobed codes are pushed one cycle after
// sampling; a pop dequeues the next cycle and updates code_o after another.
//**************************************************************************

`timescale 1ns/100ps

module kbd_fifo (
    input  logic              clk,
    input  logic              reset_i,
    input  soc_io_pkg::byte_t code_i,
    input  logic              code_strobe_i,
    input  logic              pop_i,
    output logic              not_empty_o,
    output soc_io_pkg::byte_t code_o
);
    import soc_io_pkg::*;

    byte_t      mem [0:KBD_FIFO_DEPTH-1];
    kbd_ptr_t   wr_ptr;
    kbd_ptr_t   rd_ptr;
    kbd_count_t count;

    logic  push_q;
    byte_t push_code_q;
    logic  deq_q;
    byte_t head_q;
    logic  load_q;

    logic full;
    logic can_pop;

    // Count a push already in flight so a back-to-back strobe cannot overfill
    assign full = (count == KBD_FIFO_DEPTH) ||
                  (push_q && (count == KBD_FIFO_DEPTH - 1'b1));

    // Same idea for a dequeue already in flight
    assign can_pop = (count != '0) && !(deq_q && (count == kbd_count_t'(1)));

    assign not_empty_o = (count != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            push_q <= 1'b0;
            deq_q  <= 1'b0;
            load_q <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            code_o <= '0;
        end else begin
            push_q <= code_strobe_i && !full;
            deq_q  <= pop_i && can_pop;
            load_q <= deq_q;

            if (push_q) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_q) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push_q, deq_q})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase

            if (load_q) begin
                code_o <= head_q;
            end
        end
    end

    // Storage and data staging
    always_ff @(posedge clk) begin
        if (code_strobe_i) begin
            push_code_q <= code_i;
        end
        if (push_q) begin
            mem[wr_ptr] <= push_code_q;
        end
        if (deq_q) begin
            head_q <= mem[rd_ptr];
        end
    end

endmodule

// File: hw/soc_io.sv
//**************************************************************************
// Peripheral I/O block top level. An external master drives the bus each
// cycle and reads rdata_o combinationally; the UART core sits outside.
//**************************************************************************

`timescale 1ns/100ps

module soc_io (
    input  logic                    clk,
    input  logic                    reset_i,

    // Bus master side
    input  soc_io_pkg::cpu_bus_t    bus_i,
    output soc_io_pkg::word_t       rdata_o,

    output soc_io_pkg::byte_t       display_o,

    // External UART core
    output logic                    uart_wr_o,
    output logic                    uart_rd_o,
    output soc_io_pkg::byte_t       uart_tx_data_o,
    input  soc_io_pkg::uart_in_t    uart_i,

    // USB HID report
    input  soc_io_pkg::usb_report_t usb_report_i,
    input  logic                    usb_valid_i,

    // PS/2 keyboard
    input  soc_io_pkg::byte_t       kbd_code_i,
    input  logic                    kbd_strobe_i
);
    import soc_io_pkg::*;

    io_strobe_t strobe;
    logic       kbd_not_empty;
    byte_t      kbd_code;

    io_bus_decode u_decode (
        .bus_i           (bus_i),
        .uart_i          (uart_i),
        .usb_report_i    (usb_report_i),
        .usb_valid_i     (usb_valid_i),
        .kbd_not_empty_i (kbd_not_empty),
        .kbd_code_i      (kbd_code),
        .strobe_o        (strobe),
        .rdata_o         (rdata_o)
    );

    io_out_regs u_out_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .strobe_i       (strobe),
        .wdata_i        (bus_i.wdata),
        .display_o      (display_o),
        .uart_wr_o      (uart_wr_o),
        .uart_rd_o      (uart_rd_o),
        .uart_tx_data_o (uart_tx_data_o)
    );

    // Pop strobe goes straight in, the queue ignores it when empty
    kbd_fifo u_kbd_fifo (
        .clk           (clk),
        .reset_i       (reset_i),
        .code_i        (kbd_code_i),
        .code_strobe_i (kbd_strobe_i),
        .pop_i         (strobe.kbd_pop),
        .not_empty_o   (kbd_not_empty),
        .code_o        (kbd_code)
    );

endmodule

// File: hw/soc_io_pkg.sv
//**************************************************************************
// Address map, bus types and sizes shared by the peripheral I/O block.
// Import into a module body; module ports use scoped names.
//**************************************************************************

package soc_io_pkg;

    // Bus and payload widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [63:0] usb_report_t;

    // Peripheral region in addr[31:28]
    localparam logic [3:0] REGION_PERIPH = 4'h2;

    // Device select in addr[15:12]
    localparam logic [3:0] DEV_DISPLAY = 4'h1;
    localparam logic [3:0] DEV_UART    = 4'h2;
    localparam logic [3:0] DEV_USB     = 4'h4;
    localparam logic [3:0] DEV_KBD     = 4'h5;

    // Register offsets in addr[11:0]
    localparam logic [11:0] OFS_DATA   = 12'd0;
    localparam logic [11:0] OFS_STATUS = 12'd4;
    localparam logic [11:0] OFS_LSW    = 12'd8;

    // Keyboard queue sizing
    localparam int KBD_FIFO_ADDR_LEN = 5;
    typedef logic [KBD_FIFO_ADDR_LEN-1:0] kbd_ptr_t;
    typedef logic [KBD_FIFO_ADDR_LEN:0]   kbd_count_t;
    localparam kbd_count_t KBD_FIFO_DEPTH = kbd_count_t'(1 << KBD_FIFO_ADDR_LEN);

    typedef struct packed {
        addr_t addr;
        logic  we;
        word_t wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic display_wr;
        logic uart_tx;
        logic uart_rx;
        logic kbd_pop;
    } io_strobe_t;

    typedef struct packed {
        byte_t rx_data;
        logic  busy;
        logic  valid;
    } uart_in_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the soc_io testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_soc_io -Mdir "$BUILD_DIR" -o sim_tb -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Raised error limit keeps the run going after an assertion failure
"$BUILD_DIR/sim_tb" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG_FILE"; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "No errors" "$LOG_FILE"; then
    echo "FAIL: simulation did not report a result"
    exit 1
fi
echo "PASS"
exit 0

// File: verification/soc_io_assert.sv
//**************************************************************************
// Concurrent checks on the UART pulses and the keyboard queue, bound into
// the soc_io top level.
//**************************************************************************

`timescale 1ns/100ps

module soc_io_assert (
    input logic clk,
    input logic reset_i,
    input logic uart_wr_i,
    input logic uart_rd_i,
    input logic kbd_strobe_i,
    input logic kbd_not_empty_i
);

    int unsigned wr_fails = 0;
    int unsigned rd_fails = 0;
    int unsigned kbd_fails = 0;
    int unsigned fail_total;
    logic        strobe_seen;

    assign fail_total = wr_fails + rd_fails + kbd_fails;

    // Any keyboard strobe since reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            strobe_seen <= 1'b0;
        end else if (kbd_strobe_i) begin
            strobe_seen <= 1'b1;
        end
    end

    uart_wr_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        uart_wr_i |=> !uart_wr_i)
        else begin
            wr_fails++;
            $error("uart_wr_o stayed high for two cycles");
        end

    uart_rd_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        uart_rd_i |=> !uart_rd_i)
        else begin
            rd_fails++;
            $error("uart_rd_o stayed high for two cycles");
        end

    // Queue cannot fill itself
    kbd_empty_until_strobe: assert property (@(posedge clk) disable iff (reset_i)
        !strobe_seen |-> !kbd_not_empty_i)
        else begin
            kbd_fails++;
            $error("keyboard queue not empty before any strobe");
        end

endmodule

bind soc_io soc_io_assert u_assert (
    .clk             (clk),
    .reset_i         (reset_i),
    .uart_wr_i       (uart_wr_o),
    .uart_rd_i       (uart_rd_o),
    .kbd_strobe_i    (kbd_strobe_i),
    .kbd_not_empty_i (kbd_not_empty)
);

// File: verification/soc_io_checker.sv
//**************************************************************************
// Samples the DUT outputs on each rising edge and compares them against the
// expected value of the current row. Prints a line per check and the totals.
//**************************************************************************

`timescale 1ns/100ps

module soc_io_checker #(
    parameter int NAME_W = 8*24
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              check_i,
    input  logic [2:0]        sel_i,
    input  soc_io_pkg::word_t expected_i,
    input  logic [NAME_W-1:0] name_i,
    input  logic              done_i,
    input  soc_io_pkg::word_t rdata_i,
    input  soc_io_pkg::byte_t display_i,
    input  soc_io_pkg::byte_t uart_tx_data_i,
    input  logic              uart_wr_i,
    input  logic              uart_rd_i,
    output int unsigned       check_count_o,
    output int unsigned       error_count_o
);
    import soc_io_pkg::*;

    word_t wr_pulses;
    word_t rd_pulses;
    logic  wr_prev;
    logic  rd_prev;
    word_t actual;

    // 0 selects read data, the rest pick an output or a pulse count
    always_comb begin
        case (sel_i)
            3'd0: actual = rdata_i;
            3'd1: actual = {24'd0, display_i};
            3'd2: actual = {24'd0, uart_tx_data_i};
            3'd3: actual = wr_pulses;
            3'd4: actual = rd_pulses;
            default: actual = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_pulses     <= '0;
            rd_pulses     <= '0;
            wr_prev       <= 1'b0;
            rd_prev       <= 1'b0;
            check_count_o <= 0;
            error_count_o <= 0;
        end else begin
            // Count rising edges only
            if (uart_wr_i && !wr_prev) begin
                wr_pulses <= wr_pulses + 32'd1;
            end
            if (uart_rd_i && !rd_prev) begin
                rd_pulses <= rd_pulses + 32'd1;
            end
            wr_prev <= uart_wr_i;
            rd_prev <= uart_rd_i;

            if (check_i) begin
                check_count_o <= check_count_o + 1;
                if (actual !== expected_i) begin
                    error_count_o <= error_count_o + 1;
                    $display("error %0s: expected %h, actual %h", name_i, expected_i, actual);
                end else begin
                    $display("ok %0s: %h", name_i, actual);
                end
            end
            if (done_i) begin
                $display("Checks run: %0d, failed: %0d", check_count_o, error_count_o);
            end
        end
    end

endmodule

// File: verification/soc_io_tests.txt
# op name addr data expect, all hex. W write, R read, K key, S set input, D output
# S addr 0 uart_i 1 usb high 2 usb low 3 usb valid. D addr 1 disp 2 tx 3 wr 4 rd
D display_reset 1 0 0
W display_wr_a5 20001000 000000a5 0
D display_a5 1 0 a5
W display_wr_3c 20001000 1234ff3c 0
D display_3c 1 0 3c
W uart_tx_41 20002000 00000141 0
D uart_tx_byte 2 0 41
D uart_wr_pulses 3 0 1
S uart_in 0 169 0
R uart_rx_read 20002000 0 5a
D uart_rd_pulses 4 0 1
R uart_status 20002004 0 2
S usb_high 1 cafef00d 0
S usb_low 2 12345678 0
S usb_valid 3 1 0
R usb_valid_read 20004000 0 1
R usb_high_read 20004004 0 cafef00d
R usb_low_read 20004008 0 12345678
R kbd_empty_reset 20005000 0 0
K key_1c 0 1c 0
K key_32 0 32 0
K key_21 0 21 0
R kbd_not_empty 20005000 0 1
W kbd_pop_1 20005000 0 0
R kbd_left_2 20005000 0 1
R kbd_code_1c 20005004 0 1c
W kbd_pop_2 20005000 0 0
R kbd_left_1 20005000 0 1
R kbd_code_32 20005004 0 32
W kbd_pop_3 20005000 0 0
R kbd_drained 20005000 0 0
R kbd_code_21 20005004 0 21
W kbd_pop_empty 20005000 0 0
R kbd_still_empty 20005000 0 0
R kbd_code_held 20005004 0 21
R unmapped_dev 20003000 0 0
R non_periph 10004004 0 0

// File: verification/tb_soc_io.sv
//**************************************************************************
// Testbench for soc_io. Reads bus rows from the tests file, drives them on
// falling edges and lets the checker compare the responses.
//**************************************************************************

`timescale 1ns/100ps

module tb_soc_io;
    import soc_io_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 4;
    localparam int CYCLES_PER_ROW = 2;
    localparam int NAME_W         = 8*24;

    typedef logic [NAME_W-1:0] name_t;

    logic        clk;
    logic        reset_i;
    cpu_bus_t    bus;
    word_t       rdata;
    byte_t       display;
    byte_t       uart_tx_data;
    logic        uart_wr;
    logic        uart_rd;
    uart_in_t    uart_in;
    usb_report_t usb_report;
    logic        usb_valid;
    byte_t       kbd_code;
    logic        kbd_strobe;

    logic        check;
    logic [2:0]  check_sel;
    word_t       expected;
    name_t       test_name;
    logic        done;
    int unsigned check_count;
    int unsigned error_count;
    int unsigned load_errors;
    int unsigned check_rows;
    logic        rows_loaded;
    longint      timeout_ns;

    logic [7:0]  row_op[$];
    name_t       row_name[$];
    word_t       row_addr[$];
    word_t       row_data[$];
    word_t       row_exp[$];

    soc_io dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_i          (bus),
        .rdata_o        (rdata),
        .display_o      (display),
        .uart_wr_o      (uart_wr),
        .uart_rd_o      (uart_rd),
        .uart_tx_data_o (uart_tx_data),
        .uart_i         (uart_in),
        .usb_report_i   (usb_report),
        .usb_valid_i    (usb_valid),
        .kbd_code_i     (kbd_code),
        .kbd_strobe_i   (kbd_strobe)
    );

    soc_io_checker #(.NAME_W(NAME_W)) u_checker (
        .clk            (clk),
        .reset_i        (reset_i),
        .check_i        (check),
        .sel_i          (check_sel),
        .expected_i     (expected),
        .name_i         (test_name),
        .done_i         (done),
        .rdata_i        (rdata),
        .display_i      (display),
        .uart_tx_data_i (uart_tx_data),
        .uart_wr_i      (uart_wr),
        .uart_rd_i      (uart_rd),
        .check_count_o  (check_count),
        .error_count_o  (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic load_rows();
        int fd;
        int n;
        logic [7:0] op;
        name_t name;
        word_t a;
        word_t d;
        word_t e;
        logic [8*100-1:0] rest;
        fd = $fopen("verification/soc_io_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file");
            load_errors++;
        end else begin
            n = $fscanf(fd, " %s", op);
            while (n == 1) begin
                if (op == "#") begin
                    // Rest of a comment line
                    n = $fgets(rest, fd);
                end else begin
                    n = $fscanf(fd, " %s %h %h %h", name, a, d, e);
                    if (n == 4 && op inside {"W", "R", "K", "S", "D"}) begin
                        row_op.push_back(op);
                        row_name.push_back(name);
                        row_addr.push_back(a);
                        row_data.push_back(d);
                        row_exp.push_back(e);
                        if (op inside {"R", "D"}) begin
                            check_rows++;
                        end
                    end else begin
                        $display("Malformed test row after %0d good rows", row_op.size());
                        load_errors++;
                    end
                end
                n = $fscanf(fd, " %s", op);
            end
            $fclose(fd);
        end
        if (row_op.size() == 0) begin
            $display("The test file holds no rows");
            load_errors++;
        end
    endtask

    // Access in the first cycle, idle bus in the second
    task automatic run_row(input int i);
        @(negedge clk);
        case (row_op[i])
            "W": begin
                bus.addr  <= row_addr[i];
                bus.we    <= 1'b1;
                bus.wdata <= row_data[i];
            end
            "R": begin
                bus.addr  <= row_addr[i];
                check     <= 1'b1;
                check_sel <= 3'd0;
                expected  <= row_exp[i];
            end
            "K": begin
                kbd_code   <= row_data[i][7:0];
                kbd_strobe <= 1'b1;
            end
            "S": begin
                case (row_addr[i][1:0])
                    2'd0: uart_in <= row_data[i][9:0];
                    2'd1: usb_report[63:32] <= row_data[i];
                    2'd2: usb_report[31:0] <= row_data[i];
                    default: usb_valid <= row_data[i][0];
                endcase
            end
            default: begin
                check     <= 1'b1;
                check_sel <= row_addr[i][2:0];
                expected  <= row_exp[i];
            end
        endcase
        test_name <= row_name[i];
        @(negedge clk);
        bus        <= '0;
        check      <= 1'b0;
        kbd_strobe <= 1'b0;
    endtask

    // Watchdog scaled to the number of rows
    initial begin
        wait (rows_loaded);
        timeout_ns = longint'(RESET_CYCLES + CYCLES_PER_ROW * row_op.size() + 10) * CLK_PERIOD;
        #(timeout_ns);
        $display("Watchdog timeout: the test rows did not finish in time");
        $display("Errors found");
        $finish;
    end

    initial begin
        reset_i     = 1'b1;
        bus         = '0;
        uart_in     = '0;
        usb_report  = '0;
        usb_valid   = 1'b0;
        kbd_code    = '0;
        kbd_strobe  = 1'b0;
        check       = 1'b0;
        check_sel   = '0;
        expected    = '0;
        test_name   = '0;
        done        = 1'b0;
        load_errors = 0;
        check_rows  = 0;
        rows_loaded = 1'b0;
        load_rows();
        rows_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        reset_i <= 1'b0;

        foreach (row_op[i]) begin
            run_row(i);
        end

        @(negedge clk);
        done <= 1'b1;
        @(negedge clk);
        done <= 1'b0;
        if (check_count != check_rows) begin
            $display("Checker ran %0d checks but the test file holds %0d",
                     check_count, check_rows);
        end
        if (error_count == 0 && load_errors == 0 && check_count == check_rows &&
                dut.u_assert.fail_total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
